// File: verilog/rv_exe_pkg.sv
// widths, ALU operation codes, store and load kinds, and register result targets
package rv_exe_pkg;

  localparam int XLEN       = 32;       // data and address width
  localparam int REG_ADDR_W = 5;        // register file address width
  localparam int BE_W       = XLEN / 8; // one byte enable per byte lane

  // base-set ALU operations, the decoder maps funct3/funct7 onto these
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_NONE = 2'd0, // not a store, no byte enables
    ST_SB   = 2'd1,
    ST_SH   = 2'd2,
    ST_SW   = 2'd3
  } store_op_e;

  // the u variants zero extend, the others sign extend
  typedef enum logic [2:0] {
    LD_NONE = 3'd0,
    LD_LB   = 3'd1,
    LD_LH   = 3'd2,
    LD_LW   = 3'd3,
    LD_LBU  = 3'd4,
    LD_LHU  = 3'd5
  } load_op_e;

  typedef enum logic [1:0] {
    TGT_ALU   = 2'd0, // ALU output
    TGT_STORE = 2'd1, // store data before the lane shift
    TGT_ZERO  = 2'd2,
    TGT_PC    = 2'd3  // pc+4 or branch target
  } target_e;

endpackage

// File: verilog/alu.sv
// combinational RV32I base-set ALU
`timescale 1ns/100ps

module alu (
  input  rv_exe_pkg::alu_op_e        alu_op_i, // operation picked by the decoder
  input  logic [rv_exe_pkg::XLEN-1:0] s1_i,    // first operand, always rs1
  input  logic [rv_exe_pkg::XLEN-1:0] s2_i,    // second operand, rs2 or immediate
  output logic [rv_exe_pkg::XLEN-1:0] result_o,
  output logic                        zero_o   // result is all zeros
);
  import rv_exe_pkg::*;

  logic [4:0] shamt; // only the low five bits count for RV32 shifts
  logic       lt_s;  // signed less-than
  logic       lt_u;  // unsigned less-than

  assign shamt = s2_i[4:0];
  assign lt_s  = $signed(s1_i) < $signed(s2_i);
  assign lt_u  = s1_i < s2_i;

  always_comb
  begin
    case (alu_op_i)
      ALU_ADD:  result_o = s1_i + s2_i;
      ALU_SUB:  result_o = s1_i - s2_i;
      ALU_SLL:  result_o = s1_i << shamt;
      ALU_SLT:  result_o = {{(XLEN - 1){1'b0}}, lt_s}; // set-less-than gives 0 or 1
      ALU_SLTU: result_o = {{(XLEN - 1){1'b0}}, lt_u};
      ALU_XOR:  result_o = s1_i ^ s2_i;
      ALU_SRL:  result_o = s1_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(s1_i) >>> shamt); // sign bit fills from the top
      ALU_OR:   result_o = s1_i | s2_i;
      ALU_AND:  result_o = s1_i & s2_i;
      default:  result_o = '0; // unused codes give a harmless zero
    endcase
  end

  // the branch unit in the decoder compares through sub and looks at this flag
  assign zero_o = (result_o == '0);

endmodule

// File: verilog/exe_stage.sv
// execute stage with operand select, ALU, result and store-data forming, and EX/MEM register
`timescale 1ns/100ps

module exe_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              op_valid_i,
  input  rv_exe_pkg::alu_op_e               alu_op_i,
  input  logic                              use_imm_i,  // operand 2 is the immediate
  input  logic                              use_pc4_i,  // pc target picks pc+4, not branch target
  input  logic [rv_exe_pkg::XLEN-1:0]       rs1_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       rs2_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       imm_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       pc4_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       brj_pc_i,
  input  rv_exe_pkg::target_e               target_i,
  input  logic [rv_exe_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic                              rd_wr_i,
  input  rv_exe_pkg::store_op_e             store_op_i,
  input  rv_exe_pkg::load_op_e              load_op_i,
  output logic                              ex_valid_o,
  output logic [rv_exe_pkg::REG_ADDR_W-1:0] ex_rd_addr_o,
  output logic [rv_exe_pkg::XLEN-1:0]       ex_rd_data_o,
  output logic                              ex_rd_wr_o,
  output logic [rv_exe_pkg::XLEN-1:0]       ex_addr_o,   // ALU sum doubles as data address
  output logic [rv_exe_pkg::XLEN-1:0]       ex_wdata_o,  // store data already in its lane
  output logic [rv_exe_pkg::BE_W-1:0]       ex_be_o,
  output rv_exe_pkg::load_op_e              ex_load_op_o
);
  import rv_exe_pkg::*;

  logic [XLEN-1:0] op2;        // second ALU operand
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] st_data;    // rs2 cut to the store width, still in lane 0
  logic [XLEN-1:0] st_lane;    // st_data moved to the byte lane of the address
  logic [BE_W-1:0] st_be;
  logic [XLEN-1:0] rd_data;    // register result before the pipeline register
  logic [1:0]      byte_off;   // byte offset inside the word

  assign op2      = use_imm_i ? imm_i : rs2_i;
  assign byte_off = alu_res[1:0];

  alu u_alu (
    .alu_op_i (alu_op_i),
    .s1_i     (rs1_i),
    .s2_i     (op2),
    .result_o (alu_res),
    .zero_o   ()          // branch decisions are not taken in this slice
  );

  // cut rs2 to the store width and pick the byte enables before the lane shift
  always_comb
  begin
    case (store_op_i)
      ST_SB:
      begin
        st_data = {{(XLEN - 8){1'b0}}, rs2_i[7:0]};
        st_be   = 4'b0001;
      end
      ST_SH:
      begin
        st_data = {{(XLEN - 16){1'b0}}, rs2_i[15:0]};
        st_be   = 4'b0011;
      end
      ST_SW:
      begin
        st_data = rs2_i;
        st_be   = 4'b1111;
      end
      default:
      begin
        st_data = '0; // no store, nothing gets written downstream
        st_be   = '0;
      end
    endcase
  end

  assign st_lane = st_data << {byte_off, 3'b000}; // accesses are aligned so nothing falls off

  always_comb
  begin
    case (target_i)
      TGT_ALU:   rd_data = alu_res;
      TGT_STORE: rd_data = st_data;
      TGT_ZERO:  rd_data = '0;
      default:   rd_data = use_pc4_i ? pc4_i : brj_pc_i; // link value or jump target
    endcase
  end

  // valid and control fields
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_valid_o   <= 1'b0;
      ex_rd_wr_o   <= 1'b0;
      ex_be_o      <= '0;
      ex_load_op_o <= LD_NONE;
    end
    else
    begin
      ex_valid_o   <= op_valid_i;
      ex_rd_wr_o   <= op_valid_i & rd_wr_i; // a bubble never writes the register file
      ex_be_o      <= op_valid_i ? (st_be << byte_off) : '0;
      ex_load_op_o <= load_op_i;
    end
  end

  // payload fields, only meaningful when ex_valid_o is set
  always_ff @(posedge clk)
  begin
    ex_rd_addr_o <= rd_addr_i;
    ex_rd_data_o <= rd_data;
    ex_addr_o    <= alu_res;
    ex_wdata_o   <= st_lane;
  end

endmodule

// File: verilog/mem_stage.sv
// memory stage with byte-enabled data memory, load extension, and MEM/WB register
`timescale 1ns/100ps

module mem_stage #(
  parameter int MEM_WORDS = 256 // data memory depth in words
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              ex_valid_i,
  input  logic [rv_exe_pkg::REG_ADDR_W-1:0] ex_rd_addr_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       ex_rd_data_i,
  input  logic                              ex_rd_wr_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       ex_addr_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       ex_wdata_i,
  input  logic [rv_exe_pkg::BE_W-1:0]       ex_be_i,
  input  rv_exe_pkg::load_op_e              ex_load_op_i,
  output logic                              wb_valid_o,
  output logic [rv_exe_pkg::REG_ADDR_W-1:0] wb_rd_addr_o,
  output logic [rv_exe_pkg::XLEN-1:0]       wb_rd_data_o,
  output logic                              wb_rd_wr_o
);
  import rv_exe_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [XLEN-1:0]  mem_q [MEM_WORDS]; // word-addressed data memory
  logic [IDX_W-1:0] word_idx;
  logic [XLEN-1:0]  rd_word;           // word before this cycle's write
  logic [XLEN-1:0]  rd_shift;          // addressed byte or half moved to bit 0
  logic [XLEN-1:0]  ld_data;           // extended load result
  logic [XLEN-1:0]  rd_data;

  // the word bits of the address wrap around the memory size
  assign word_idx = IDX_W'(ex_addr_i[XLEN-1:2] % MEM_WORDS);
  assign rd_word  = mem_q[word_idx];
  assign rd_shift = rd_word >> {ex_addr_i[1:0], 3'b000};

  always_comb
  begin
    case (ex_load_op_i)
      LD_LB:   ld_data = {{(XLEN - 8){rd_shift[7]}}, rd_shift[7:0]};
      LD_LH:   ld_data = {{(XLEN - 16){rd_shift[15]}}, rd_shift[15:0]};
      LD_LBU:  ld_data = {{(XLEN - 8){1'b0}}, rd_shift[7:0]};
      LD_LHU:  ld_data = {{(XLEN - 16){1'b0}}, rd_shift[15:0]};
      default: ld_data = rd_word; // lw takes the whole word
    endcase
  end

  // loads replace the execute result, every other operation keeps it
  assign rd_data = (ex_load_op_i != LD_NONE) ? ld_data : ex_rd_data_i;

  // byte lanes are written one by one under their enables
  always_ff @(posedge clk)
  begin
    if (ex_valid_i)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (ex_be_i[b])
          mem_q[word_idx][8*b +: 8] <= ex_wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_valid_o <= 1'b0;
      wb_rd_wr_o <= 1'b0;
    end
    else
    begin
      wb_valid_o <= ex_valid_i;
      wb_rd_wr_o <= ex_valid_i & ex_rd_wr_i;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_rd_addr_o <= ex_rd_addr_i; // payload follows wb_valid_o
    wb_rd_data_o <= rd_data;
  end

endmodule

// File: verilog/result_buffer.sv
// writeback record FIFO with downstream credit counter and upstream credit return
`timescale 1ns/100ps

module result_buffer #(
  parameter int BUF_DEPTH = 4 // entries, equal to the issuer's starting credits
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wb_valid_i,
  input  logic [rv_exe_pkg::REG_ADDR_W-1:0] wb_rd_addr_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       wb_rd_data_i,
  input  logic                              wb_rd_wr_i,
  input  logic                              res_credit_i,  // one pulse per result the consumer can take
  output logic                              res_valid_o,
  output logic [rv_exe_pkg::REG_ADDR_W-1:0] res_rd_addr_o,
  output logic [rv_exe_pkg::XLEN-1:0]       res_rd_data_o,
  output logic                              res_rd_wr_o,
  output logic                              op_credit_o    // one entry freed, back to the issuer
);
  import rv_exe_pkg::*;

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);
  localparam int CRD_W = 16;                    // the consumer may grant well ahead of results
  localparam int ENT_W = 1 + REG_ADDR_W + XLEN; // {rd_wr, rd_addr, rd_data}

  logic [ENT_W-1:0] entry_q [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;  // occupied entries
  logic [CRD_W-1:0] crd_q;    // downstream credits not yet spent
  logic [ENT_W-1:0] wb_entry;
  logic [ENT_W-1:0] head;
  logic             send;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1; // wrap for any depth
  endfunction

  assign wb_entry = {wb_rd_wr_i, wb_rd_addr_i, wb_rd_data_i};
  // an empty buffer hands the arriving record straight to the output register
  assign head = (count_q == '0) ? wb_entry : entry_q[rd_ptr_q];
  assign send = ((count_q != '0) || wb_valid_i) && (crd_q != '0);

  always_ff @(posedge clk)
  begin
    if (wb_valid_i)
      entry_q[wr_ptr_q] <= wb_entry; // also written on bypass, then popped at once
    if (send)
      {res_rd_wr_o, res_rd_addr_o, res_rd_data_o} <= head;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      crd_q       <= '0;
      res_valid_o <= 1'b0;
      op_credit_o <= 1'b0;
    end
    else
    begin
      if (wb_valid_i)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (send)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q     <= count_q + CNT_W'(wb_valid_i) - CNT_W'(send);
      crd_q       <= crd_q + CRD_W'(res_credit_i) - CRD_W'(send);
      res_valid_o <= send;
      op_credit_o <= send; // the freed slot goes back upstream with the record
    end
  end

endmodule

// File: verilog/exe_mem_top.sv
// top level joining the execute stage, the memory stage and the result buffer
`timescale 1ns/100ps

module exe_mem_top #(
  parameter int MEM_WORDS = 256, // data memory depth in words
  parameter int BUF_DEPTH = 4    // result buffer entries
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              op_valid_i,  // only raised while the issuer holds a credit
  input  rv_exe_pkg::alu_op_e               alu_op_i,
  input  logic                              use_imm_i,
  input  logic                              use_pc4_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       rs1_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       rs2_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       imm_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       pc4_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       brj_pc_i,
  input  rv_exe_pkg::target_e               target_i,
  input  logic [rv_exe_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic                              rd_wr_i,
  input  rv_exe_pkg::store_op_e             store_op_i,
  input  rv_exe_pkg::load_op_e              load_op_i,
  input  logic                              res_credit_i,
  output logic                              res_valid_o,
  output logic [rv_exe_pkg::REG_ADDR_W-1:0] res_rd_addr_o,
  output logic [rv_exe_pkg::XLEN-1:0]       res_rd_data_o,
  output logic                              res_rd_wr_o,
  output logic                              op_credit_o
);
  import rv_exe_pkg::*;

  // execute to memory
  logic                  ex_valid;
  logic [REG_ADDR_W-1:0] ex_rd_addr;
  logic [XLEN-1:0]       ex_rd_data;
  logic                  ex_rd_wr;
  logic [XLEN-1:0]       ex_addr;
  logic [XLEN-1:0]       ex_wdata;
  logic [BE_W-1:0]       ex_be;
  load_op_e              ex_load_op;
  // memory to result buffer
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd_addr;
  logic [XLEN-1:0]       wb_rd_data;
  logic                  wb_rd_wr;

  exe_stage u_exe (
    .clk          (clk),          .rst_n        (rst_n),
    .op_valid_i   (op_valid_i),   .alu_op_i     (alu_op_i),
    .use_imm_i    (use_imm_i),    .use_pc4_i    (use_pc4_i),
    .rs1_i        (rs1_i),        .rs2_i        (rs2_i),
    .imm_i        (imm_i),        .pc4_i        (pc4_i),
    .brj_pc_i     (brj_pc_i),     .target_i     (target_i),
    .rd_addr_i    (rd_addr_i),    .rd_wr_i      (rd_wr_i),
    .store_op_i   (store_op_i),   .load_op_i    (load_op_i),
    .ex_valid_o   (ex_valid),     .ex_rd_addr_o (ex_rd_addr),
    .ex_rd_data_o (ex_rd_data),   .ex_rd_wr_o   (ex_rd_wr),
    .ex_addr_o    (ex_addr),      .ex_wdata_o   (ex_wdata),
    .ex_be_o      (ex_be),        .ex_load_op_o (ex_load_op)
  );

  mem_stage #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk          (clk),          .rst_n        (rst_n),
    .ex_valid_i   (ex_valid),     .ex_rd_addr_i (ex_rd_addr),
    .ex_rd_data_i (ex_rd_data),   .ex_rd_wr_i   (ex_rd_wr),
    .ex_addr_i    (ex_addr),      .ex_wdata_i   (ex_wdata),
    .ex_be_i      (ex_be),        .ex_load_op_i (ex_load_op),
    .wb_valid_o   (wb_valid),     .wb_rd_addr_o (wb_rd_addr),
    .wb_rd_data_o (wb_rd_data),   .wb_rd_wr_o   (wb_rd_wr)
  );

  result_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
    .clk           (clk),           .rst_n         (rst_n),
    .wb_valid_i    (wb_valid),      .wb_rd_addr_i  (wb_rd_addr),
    .wb_rd_data_i  (wb_rd_data),    .wb_rd_wr_i    (wb_rd_wr),
    .res_credit_i  (res_credit_i),  .res_valid_o   (res_valid_o),
    .res_rd_addr_o (res_rd_addr_o), .res_rd_data_o (res_rd_data_o),
    .res_rd_wr_o   (res_rd_wr_o),   .op_credit_o   (op_credit_o)
  );

endmodule

// File: verif/tb_checker.sv
// checker with ALU, target and byte-memory models, expected-record queue, comparisons and report
`timescale 1ns/100ps

module tb_checker #(
  parameter int MEM_WORDS = 256,
  parameter int BUF_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              op_valid_i,
  input  rv_exe_pkg::alu_op_e               alu_op_i,
  input  logic                              use_imm_i,
  input  logic                              use_pc4_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       rs1_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       rs2_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       imm_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       pc4_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       brj_pc_i,
  input  rv_exe_pkg::target_e               target_i,
  input  logic [rv_exe_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic                              rd_wr_i,
  input  rv_exe_pkg::store_op_e             store_op_i,
  input  rv_exe_pkg::load_op_e              load_op_i,
  input  logic                              res_credit_i,
  input  logic                              res_valid_i,
  input  logic [rv_exe_pkg::REG_ADDR_W-1:0] res_rd_addr_i,
  input  logic [rv_exe_pkg::XLEN-1:0]       res_rd_data_i,
  input  logic                              res_rd_wr_i,
  input  logic                              op_credit_i,
  input  int                                test_id_i,
  input  logic                              test_end_i,
  output int                                tests_ok_o,
  output int                                tests_bad_o,
  output int                                errors_o
);
  import rv_exe_pkg::*;

  logic [37:0] exp_q [$];               // {rd_wr, rd_addr, rd_data} in issue order
  logic [7:0]  mem_model [MEM_WORDS*4]; // byte view of the data memory
  int          issued_n;                // counted on rising edges
  int          granted_n;
  int          cur_test;
  logic        end_seen;
  int          returned_n;              // counted on falling edges
  int          sent_n;
  int          n_rec;
  int          n_err;

  function automatic string test_name(input int id);
    case (id)
      1:       test_name = "reset_idle";
      2:       test_name = "alu_ops";
      3:       test_name = "targets";
      4:       test_name = "store_load";
      5:       test_name = "credit_stress";
      default: test_name = "none";
    endcase
  endfunction

  // the RV32I rules, slt looks at the sign bits first
  function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:  alu_model = a + b;
      ALU_SUB:  alu_model = a + ~b + 32'd1;
      ALU_SLL:  alu_model = a << sh;
      ALU_SLT:  alu_model = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      ALU_SLTU: alu_model = {31'b0, a < b};
      ALU_XOR:  alu_model = a ^ b;
      ALU_SRL:  alu_model = a >> sh;
      ALU_SRA:  alu_model = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      ALU_OR:   alu_model = a | b;
      ALU_AND:  alu_model = a & b;
      default:  alu_model = '0;
    endcase
  endfunction

  // word bits wrap around the memory size, as on the DUT
  function automatic int byte_at(input logic [31:0] addr);
    byte_at = int'((addr >> 2) % MEM_WORDS) * 4 + int'(addr[1:0]);
  endfunction

  function automatic logic [31:0] load_model(input load_op_e op, input logic [31:0] addr);
    logic [7:0]  b0;
    logic [15:0] h;
    b0 = mem_model[byte_at(addr)];
    h  = {mem_model[byte_at(addr + 1)], b0};
    case (op)
      LD_LB:   load_model = {{24{b0[7]}}, b0};
      LD_LBU:  load_model = {24'b0, b0};
      LD_LH:   load_model = {{16{h[15]}}, h};
      LD_LHU:  load_model = {16'b0, h};
      default: load_model = {mem_model[byte_at(addr + 3)], mem_model[byte_at(addr + 2)], h};
    endcase
  endfunction

  // inputs are stable at the rising edge, so expected records are formed here
  always @(posedge clk)
  begin : model_issue
    logic [31:0] op2;
    logic [31:0] a;
    logic [31:0] st;
    logic [31:0] rd;
    int          size;
    cur_test = test_id_i;
    end_seen = test_end_i;
    if (!rst_n)
    begin
      issued_n  = 0;
      granted_n = 0;
    end
    else
    begin
      if (res_credit_i)
        granted_n++;
      if (op_valid_i)
      begin
        issued_n++;
        op2 = use_imm_i ? imm_i : rs2_i;
        a   = alu_model(alu_op_i, rs1_i, op2); // also the data address
        case (store_op_i)
          ST_SB:
          begin
            st   = {24'b0, rs2_i[7:0]};
            size = 1;
          end
          ST_SH:
          begin
            st   = {16'b0, rs2_i[15:0]};
            size = 2;
          end
          ST_SW:
          begin
            st   = rs2_i;
            size = 4;
          end
          default:
          begin
            st   = '0;
            size = 0;
          end
        endcase
        case (target_i)
          TGT_ALU:   rd = a;
          TGT_STORE: rd = st;
          TGT_ZERO:  rd = '0;
          default:   rd = use_pc4_i ? pc4_i : brj_pc_i;
        endcase
        if (load_op_i != LD_NONE)
          rd = load_model(load_op_i, a); // reads the memory as it was before this op
        for (int b = 0; b < size; b++)
          mem_model[byte_at(a + 32'(b))] = st[8*b +: 8];
        exp_q.push_back({rd_wr_i, rd_addr_i, rd});
      end
    end
  end

  // outputs change on the rising edge and are compared on the falling one
  always @(negedge clk)
  begin : compare
    logic [37:0] exp;
    int          icred;
    if (!rst_n)
    begin
      returned_n  = 0;
      sent_n      = 0;
      n_rec       = 0;
      n_err       = 0;
      tests_ok_o  = 0;
      tests_bad_o = 0;
      errors_o    = 0;
    end
    else
    begin
      if (end_seen)
      begin
        if (exp_q.size() != 0)
        begin
          $display("%s: %0d records never arrived", test_name(cur_test), exp_q.size());
          n_err++;
          exp_q.delete();
        end
        $display("test %0d %s: %0d records, %0d errors, %s", cur_test, test_name(cur_test),
                 n_rec, n_err, (n_err == 0) ? "ok" : "bad");
        if (n_err == 0)
          tests_ok_o++;
        else
          tests_bad_o++;
        errors_o += n_err;
        n_rec = 0;
        n_err = 0;
      end
      if (op_credit_i !== res_valid_i)
      begin
        $display("%s: op_credit_o did not pulse together with res_valid_o", test_name(cur_test));
        n_err++;
      end
      if (res_valid_i === 1'b1)
      begin
        sent_n++;
        n_rec++;
        if (sent_n > granted_n) // more records than the consumer asked for
        begin
          $display("%s: a record was sent without a downstream credit", test_name(cur_test));
          n_err++;
        end
        if (exp_q.size() == 0)
        begin
          $display("%s: a record arrived with no operation outstanding", test_name(cur_test));
          n_err++;
        end
        else
        begin
          exp = exp_q.pop_front();
          if ({res_rd_wr_i, res_rd_addr_i, res_rd_data_i} !== exp)
          begin
            $display("** Error %s: expected wr=%0d rd=%0d data=%h, actual wr=%0d rd=%0d data=%h",
                     test_name(cur_test), exp[37], exp[36:32], exp[31:0],
                     res_rd_wr_i, res_rd_addr_i, res_rd_data_i);
            n_err++;
          end
        end
      end
      if (op_credit_i === 1'b1)
        returned_n++;
      icred = BUF_DEPTH - issued_n + returned_n; // what the issuer should hold now
      if (icred < 0 || icred > BUF_DEPTH)
      begin
        $display("%s: issuer credits left the range 0 to %0d", test_name(cur_test), BUF_DEPTH);
        n_err++;
      end
    end
  end

endmodule

// File: verif/tb_top.sv
// testbench top with clock, reset, credit-limited random issue, credit grants and the DUT
`timescale 1ns/100ps

module tb_top;
  import rv_exe_pkg::*;

  localparam int          MEM_WORDS    = 256;
  localparam int          BUF_DEPTH    = 4;
  localparam int          WAIT_MAX     = 400;           // longest any wait may take, in cycles
  localparam logic [31:0] REGION       = 32'h8000_0200; // data region that wraps onto word 0x80
  localparam int          REGION_WORDS = 32;
  localparam int          K_ALU        = 0;             // kinds of random operation
  localparam int          K_TGT        = 1;
  localparam int          K_STORE      = 2;
  localparam int          K_LOAD       = 3;
  localparam int          K_FILL       = 4;

  logic                  clk;
  logic                  rst_n;
  logic                  op_valid_i;
  alu_op_e               alu_op_i;
  logic                  use_imm_i;
  logic                  use_pc4_i;
  logic [XLEN-1:0]       rs1_i;
  logic [XLEN-1:0]       rs2_i;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       pc4_i;
  logic [XLEN-1:0]       brj_pc_i;
  target_e               target_i;
  logic [REG_ADDR_W-1:0] rd_addr_i;
  logic                  rd_wr_i;
  store_op_e             store_op_i;
  load_op_e              load_op_i;
  logic                  res_credit_i;
  logic                  res_valid_o;
  logic [REG_ADDR_W-1:0] res_rd_addr_o;
  logic [XLEN-1:0]       res_rd_data_o;
  logic                  res_rd_wr_o;
  logic                  op_credit_o;

  int   test_id;    // number of the current test, named by the checker
  logic test_end;   // one-cycle pulse after which the checker reports the test
  int   credits;    // issuer credits held
  int   issued;
  int   granted;    // downstream credits handed out so far
  int   received;
  int   grant_pct;  // chance per cycle of a downstream grant
  logic timed_out;
  int   tests_ok;
  int   tests_bad;
  int   errors;

  always #5 clk = ~clk;

  exe_mem_top #(.MEM_WORDS(MEM_WORDS), .BUF_DEPTH(BUF_DEPTH)) UUT (.*);

  tb_checker #(.MEM_WORDS(MEM_WORDS), .BUF_DEPTH(BUF_DEPTH)) chk (
    .*,
    .res_valid_i   (res_valid_o),
    .res_rd_addr_i (res_rd_addr_o),
    .res_rd_data_i (res_rd_data_o),
    .res_rd_wr_i   (res_rd_wr_o),
    .op_credit_i   (op_credit_o),
    .test_id_i     (test_id),
    .test_end_i    (test_end),
    .tests_ok_o    (tests_ok),
    .tests_bad_o   (tests_bad),
    .errors_o      (errors)
  );

  // one falling edge that books returned credits and records and may grant a credit
  task automatic advance();
    @(negedge clk);
    if (op_credit_o)
      credits++;
    if (res_valid_o)
      received++;
    op_valid_i   = 1'b0;
    test_end     = 1'b0;
    res_credit_i = 1'b0;
    if (granted < issued && ($urandom % 100) < grant_pct) // never grant beyond the results due
    begin
      res_credit_i = 1'b1;
      granted++;
    end
  endtask

  // random address in the data region, aligned to the access size
  function automatic logic [31:0] pick_addr(input int size);
    logic [31:0] a;
    a         = REGION + ($urandom % (REGION_WORDS * 4));
    pick_addr = a & ~(32'(size) - 32'd1);
  endfunction

  // rs1 plus a random signed 12-bit offset lands on addr
  task automatic aim_at(input logic [31:0] addr);
    logic [11:0] off;
    off       = 12'($urandom);
    alu_op_i  = ALU_ADD;
    use_imm_i = 1'b1;
    imm_i     = {{20{off[11]}}, off};
    rs1_i     = addr - imm_i;
  endtask

  task automatic fill_fields(input int kind, input logic [31:0] addr);
    int size;
    alu_op_i   = alu_op_e'(4'($urandom % 10));
    use_imm_i  = 1'($urandom);
    use_pc4_i  = 1'($urandom);
    rs1_i      = $urandom;
    rs2_i      = ($urandom % 4 == 0) ? rs1_i : $urandom; // equal operands now and then
    imm_i      = $urandom;
    pc4_i      = $urandom & ~32'h3;
    brj_pc_i   = $urandom & ~32'h1;
    target_i   = TGT_ALU;
    rd_addr_i  = 5'($urandom);
    rd_wr_i    = 1'($urandom);
    store_op_i = ST_NONE;
    load_op_i  = LD_NONE;
    case (kind)
      K_TGT:
      begin
        target_i   = target_e'(2'($urandom));
        store_op_i = store_op_e'(2'($urandom));
        if (store_op_i != ST_NONE)
          aim_at(pick_addr(1 << (int'(store_op_i) - 1))); // sb 1, sh 2, sw 4 bytes
      end
      K_STORE:
      begin
        store_op_i = store_op_e'(2'(1 + $urandom % 3));
        target_i   = target_e'(2'($urandom));
        aim_at(pick_addr(1 << (int'(store_op_i) - 1)));
      end
      K_LOAD:
      begin
        load_op_i = load_op_e'(3'(1 + $urandom % 5));
        case (load_op_i)
          LD_LH, LD_LHU: size = 2;
          LD_LW:         size = 4;
          default:       size = 1;
        endcase
        aim_at(pick_addr(size));
      end
      K_FILL:
      begin
        store_op_i = ST_SW;
        rs2_i      = {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5; // fill word follows the address
        aim_at(addr);
      end
      default: ;
    endcase
  endtask

  // waits for an issuer credit, then drives one operation for one cycle
  task automatic send_op(input int kind, input logic [31:0] addr);
    int n;
    if (!timed_out)
    begin
      advance();
      n = 0;
      while (credits == 0 && n < WAIT_MAX)
      begin
        advance();
        n++;
      end
      if (credits == 0)
      begin
        $display("timeout: no issuer credit came back within %0d cycles", WAIT_MAX);
        timed_out = 1'b1;
      end
      else
      begin
        fill_fields(kind, addr);
        op_valid_i = 1'b1;
        credits--;
        issued++;
      end
    end
  endtask

  // grants credits until every issued operation has returned its record
  task automatic finish_test();
    int n;
    grant_pct = 50;
    n         = 0;
    while (received < issued && n < WAIT_MAX && !timed_out)
    begin
      advance();
      n++;
    end
    if (received < issued && !timed_out)
    begin
      $display("timeout: %0d records still missing after %0d cycles", issued - received, WAIT_MAX);
      timed_out = 1'b1;
    end
    advance();
    test_end = 1'b1; // seen by the checker at the next rising edge
    advance();
    advance();       // the checker has booked the test by this edge
  endtask

  initial
  begin
    void'($urandom(40999));
    clk          = 1'b0;
    rst_n        = 1'b0;
    op_valid_i   = 1'b0;
    fill_fields(K_ALU, '0);
    res_credit_i = 1'b0;
    test_id      = 0;
    test_end     = 1'b0;
    credits      = BUF_DEPTH; // one per buffer entry
    issued       = 0;
    granted      = 0;
    received     = 0;
    grant_pct    = 0;
    timed_out    = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    test_id = 1; // idle pipeline with no downstream credit
    repeat (20) advance();
    finish_test();

    test_id   = 2;
    grant_pct = 70;
    repeat (300) send_op(K_ALU, '0);
    finish_test();

    test_id   = 3;
    grant_pct = 70;
    repeat (200) send_op(K_TGT, '0);
    finish_test();

    test_id   = 4;
    grant_pct = 70;
    for (int w = 0; w < REGION_WORDS; w++)
      send_op(K_FILL, REGION + 32'(w * 4)); // every region word is written before any load
    repeat (300) send_op(($urandom % 2 == 0) ? K_STORE : K_LOAD, '0);
    finish_test();

    test_id = 5;
    for (int i = 0; i < 400; i++)
    begin
      if (i % 50 == 25)
      begin
        grant_pct = 0; // the consumer stalls and records pile up in the buffer
        repeat (60) advance();
        grant_pct = 5 + int'($urandom % 90);
      end
      send_op(int'($urandom % 4), '0);
    end
    finish_test();

    $display("closing: %0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
    if (timed_out || tests_bad != 0 || errors != 0)
      $display("TESTS FAILED");
    else
      $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: tb.f
verilog/rv_exe_pkg.sv
verilog/alu.sv
verilog/exe_stage.sv
verilog/mem_stage.sv
verilog/result_buffer.sv
verilog/exe_mem_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
